/* build.f */
hw/padframe_pkg.sv
hw/padframe_cfg_regs.sv
hw/pad_mux.sv
hw/padframe_top.sv
verification/padframe_asserts.sv
verification/padframe_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal --timescale 1ns/1ps
TOP       = padframe_tb
FILELIST  = build.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
SIM_ARGS  = +verilator+error+limit+100
PASS_MSG  = Finished with no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$($(SIM) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* verification/padframe_tb.sv */
/*
 * Pad frame testbench
 * Directed and random register accesses with random peripheral levels
 * and an external pad model. The bound assertions check the DUT.
 */
module padframe_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import padframe_pkg::*;

  localparam int unsigned NUM_PADS    = 8;
  localparam int unsigned NUM_REGS    = 3 + NUM_PADS;
  localparam int unsigned GPIO_ROUNDS = 40;
  localparam int unsigned SEL_ROUNDS  = 150;
  localparam int unsigned RAND_OPS    = 150;
  // Rough upper bound on the stimulus
  localparam int unsigned TEST_CYCLES     = 1000;
  // Twice the stimulus length for margin
  localparam int unsigned WATCHDOG_CYCLES = 2 * TEST_CYCLES;

  // Addresses the slave must refuse
  localparam reg_addr_t BAD_ADDR [6] = '{
    REG_GPIO_IN, 32'h0000_0002, 32'h0000_0013,
    32'h0000_000C, REG_PAD_SEL_BASE + 4 * NUM_PADS, 32'h8000_0010
  };

  logic                clk_i = 1'b0;
  logic                reset_i;
  logic                reg_valid_i, reg_write_i;
  reg_addr_t           reg_addr_i;
  reg_data_t           reg_wdata_i;
  logic                reg_ready_o, reg_error_o;
  reg_data_t           reg_rdata_o;
  logic                uart_tx_i = 1'b1;
  logic                spi_sck_i = 1'b0;
  logic                spi_mosi_i = 1'b0;
  logic                spi_csn_i = 1'b1;
  logic                uart_rx_o, spi_miso_o;
  logic [NUM_PADS-1:0] pad_in_i = '0;
  logic [NUM_PADS-1:0] pad_out_o, pad_oe_o;

  // One generator stream for the bus and one for the pad side
  logic [31:0]         lcg_state = 32'd65;
  logic [31:0]         pin_lcg_state = 32'd65;

  padframe_top #(
    .NUM_PADS ( NUM_PADS )
  ) dut0 (.*);

  always #50 clk_i = ~clk_i;

  function automatic logic [15:0] lcg_next(inout logic [31:0] state);
    state = state * 32'd1664525 + 32'd1013904223;
    return state[31:16];
  endfunction

  // Bus data word from the bus stream
  function automatic reg_data_t rand_word();
    logic [15:0] hi;
    logic [15:0] lo;
    hi = lcg_next(lcg_state);
    lo = lcg_next(lcg_state);
    return {hi, lo};
  endfunction

  // Register n in map order
  // One past the last select is unmapped
  function automatic reg_addr_t reg_addr_of(int unsigned n);
    if (n < 3) begin
      return reg_addr_t'(4 * n);
    end
    return REG_PAD_SEL_BASE + reg_addr_t'(4 * (n - 3));
  endfunction

  task automatic stop_with_failure(input string reason);
    $display("Finished with errors");
    $fatal(1, "%s", reason);
  endtask

  // Starts and ends on a falling edge
  task automatic bus_access(input logic write, input reg_addr_t addr, input reg_data_t wdata);
    reg_valid_i = 1'b1;
    reg_write_i = write;
    reg_addr_i  = addr;
    reg_wdata_i = wdata;
    @(posedge clk_i);
    while (!reg_ready_o) begin
      @(posedge clk_i);
    end
    @(negedge clk_i);
    reg_valid_i = 1'b0;
  endtask

  task automatic read_all_regs();
    for (int n = 0; n < NUM_REGS; n++) begin
      bus_access(1'b0, reg_addr_of(n), '0);
    end
  endtask

  // Peripheral levels and the far side of the pads
  always @(negedge clk_i) begin
    logic [15:0] r;
    logic [15:0] pins;
    r          = lcg_next(pin_lcg_state);
    pins       = lcg_next(pin_lcg_state);
    uart_tx_i  = r[0];
    spi_sck_i  = r[1];
    spi_mosi_i = r[2];
    spi_csn_i  = r[3];
    // Driven pads read back their own level
    if (reset_i) begin
      pad_in_i = pins[NUM_PADS-1:0];
    end else begin
      pad_in_i = (pad_out_o & pad_oe_o) | (pins[NUM_PADS-1:0] & ~pad_oe_o);
    end
  end

  initial begin
    logic [15:0] r;
    reset_i     = 1'b1;
    reg_valid_i = 1'b0;
    reg_write_i = 1'b0;
    reg_addr_i  = '0;
    reg_wdata_i = '0;
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;

    read_all_regs();

    // Every pad owned by GPIO
    for (int p = 0; p < NUM_PADS; p++) begin
      bus_access(1'b1, reg_addr_of(3 + p), reg_data_t'(PAD_GPIO));
    end
    repeat (GPIO_ROUNDS) begin
      bus_access(1'b1, REG_GPIO_OUT, rand_word());
      bus_access(1'b1, REG_GPIO_DIR, rand_word());
      bus_access(1'b0, REG_GPIO_IN, '0);
    end

    // Random owners with frequent sharing
    repeat (SEL_ROUNDS) begin
      r = lcg_next(lcg_state);
      bus_access(1'b1, reg_addr_of(3 + (r % NUM_PADS)), rand_word());
      if (r[9]) begin
        bus_access(1'b0, reg_addr_of(3 + (r % NUM_PADS)), '0);
      end
      if (r[10]) begin
        bus_access(1'b1, r[11] ? REG_GPIO_DIR : REG_GPIO_OUT, rand_word());
      end
    end

    foreach (BAD_ADDR[k]) begin
      bus_access(1'b1, BAD_ADDR[k], rand_word());
      bus_access(1'b0, BAD_ADDR[k], '0);
    end
    read_all_regs();

    repeat (RAND_OPS) begin
      r = lcg_next(lcg_state);
      bus_access(r[15], reg_addr_of(r % (NUM_REGS + 1)), rand_word());
    end

    repeat (2) @(negedge clk_i);
    if (dut0.i_asserts.fail_count != 0) begin
      stop_with_failure("Assertion failures during the run");
    end else begin
      $display("Finished with no errors");
      $finish;
    end
  end

  // First failed assertion ends the run
  always @(negedge clk_i) begin
    if (dut0.i_asserts.fail_count != 0) begin
      stop_with_failure("An assertion on the DUT failed");
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    stop_with_failure("Watchdog timeout, the stimulus did not complete in time");
  end

endmodule

/* verification/padframe_asserts.sv */
/*
 * Pad frame assertions
 * Keeps a shadow of the register writes the DUT accepted and a two-stage
 * copy of the pad inputs, and checks bus responses and pads against them
 */
module padframe_asserts #(
  parameter int unsigned NUM_PADS = 8
) (
  input logic                    clk_i,
  input logic                    reset_i,
  input logic                    reg_valid_i,
  input logic                    reg_write_i,
  input padframe_pkg::reg_addr_t reg_addr_i,
  input padframe_pkg::reg_data_t reg_wdata_i,
  input logic                    reg_ready_o,
  input padframe_pkg::reg_data_t reg_rdata_o,
  input logic                    reg_error_o,
  input logic                    uart_tx_i,
  input logic                    uart_rx_o,
  input logic                    spi_sck_i,
  input logic                    spi_mosi_i,
  input logic                    spi_csn_i,
  input logic                    spi_miso_o,
  input logic [NUM_PADS-1:0]     pad_in_i,
  input logic [NUM_PADS-1:0]     pad_out_o,
  input logic [NUM_PADS-1:0]     pad_oe_o
);
  timeunit 1ns;
  timeprecision 1ps;
  import padframe_pkg::*;

  int unsigned fail_count = 0;

  logic [NUM_PADS-1:0]  out_s, dir_s, in_d1, in_d2;
  logic [PAD_SEL_W-1:0] sel_s [NUM_PADS];
  logic [REG_AW-1:0]    sel_pad;
  logic                 is_sel;
  logic                 exp_err;
  reg_data_t            exp_rdata;
  logic [NUM_PADS-1:0]  exp_out, exp_oe;
  logic                 exp_rx, exp_miso, rx_seen, miso_seen;

  // Expected bus response from the register map
  always_comb begin
    sel_pad   = (reg_addr_i - REG_PAD_SEL_BASE) >> 2;
    is_sel    = (reg_addr_i >= REG_PAD_SEL_BASE) && (reg_addr_i[1:0] == 2'b00)
             && (sel_pad < NUM_PADS);
    exp_err   = !((reg_addr_i inside {REG_GPIO_OUT, REG_GPIO_DIR, REG_GPIO_IN}) || is_sel)
             || (reg_write_i && reg_addr_i == REG_GPIO_IN);
    exp_rdata = '0;
    if (!exp_err) begin
      case (reg_addr_i)
        REG_GPIO_OUT: exp_rdata = reg_data_t'(out_s);
        REG_GPIO_DIR: exp_rdata = reg_data_t'(dir_s);
        REG_GPIO_IN:  exp_rdata = reg_data_t'(in_d2);
        default:      exp_rdata = reg_data_t'(sel_s[sel_pad]);
      endcase
    end
  end

  // Expected pad side from the function table
  always_comb begin
    exp_out   = '0;
    exp_oe    = '0;
    exp_rx    = 1'b1;
    exp_miso  = 1'b0;
    rx_seen   = 1'b0;
    miso_seen = 1'b0;
    for (int i = 0; i < NUM_PADS; i++) begin
      case (sel_s[i])
        PAD_GPIO:     {exp_oe[i], exp_out[i]} = {dir_s[i], out_s[i]};
        PAD_UART_TX:  {exp_oe[i], exp_out[i]} = {1'b1, uart_tx_i};
        PAD_SPI_SCK:  {exp_oe[i], exp_out[i]} = {1'b1, spi_sck_i};
        PAD_SPI_MOSI: {exp_oe[i], exp_out[i]} = {1'b1, spi_mosi_i};
        PAD_SPI_CSN:  {exp_oe[i], exp_out[i]} = {1'b1, spi_csn_i};
        default:      {exp_oe[i], exp_out[i]} = 2'b00;
      endcase
      if (sel_s[i] == PAD_UART_RX && !rx_seen) begin
        exp_rx  = pad_in_i[i];
        rx_seen = 1'b1;
      end
      if (sel_s[i] == PAD_SPI_MISO && !miso_seen) begin
        exp_miso  = pad_in_i[i];
        miso_seen = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      out_s <= '0;
      dir_s <= '0;
      in_d1 <= '0;
      in_d2 <= '0;
      for (int i = 0; i < NUM_PADS; i++) begin
        sel_s[i] <= PAD_OFF;
      end
    end else begin
      in_d1 <= pad_in_i;
      in_d2 <= in_d1;
      // Only writes the slave did not refuse
      if (reg_valid_i && reg_write_i && !reg_error_o) begin
        if (reg_addr_i == REG_GPIO_OUT) begin
          out_s <= reg_wdata_i[NUM_PADS-1:0];
        end
        if (reg_addr_i == REG_GPIO_DIR) begin
          dir_s <= reg_wdata_i[NUM_PADS-1:0];
        end
        if (is_sel) begin
          sel_s[sel_pad] <= reg_wdata_i[PAD_SEL_W-1:0];
        end
      end
    end
  end

  assert property (@(posedge clk_i) reg_ready_o == reg_valid_i) else begin
    fail_count++;
    $error("FAIL %0t: reg_ready_o differs from reg_valid_i", $time);
  end

  assert property (@(posedge clk_i) disable iff (reset_i)
                   reg_valid_i |-> reg_error_o == exp_err) else begin
    fail_count++;
    $error("FAIL %0t: reg_error_o wrong for address %h", $time, reg_addr_i);
  end

  assert property (@(posedge clk_i) disable iff (reset_i)
                   reg_valid_i && !reg_write_i |-> reg_rdata_o == exp_rdata) else begin
    fail_count++;
    $error("FAIL %0t: read of %h returned %h, expected %h",
           $time, reg_addr_i, reg_rdata_o, exp_rdata);
  end

  assert property (@(posedge clk_i) disable iff (reset_i)
                   pad_out_o == exp_out && pad_oe_o == exp_oe
                   && uart_rx_o == exp_rx && spi_miso_o == exp_miso) else begin
    fail_count++;
    $error("FAIL %0t: pad out %b oe %b rx %b miso %b, expected %b %b %b %b", $time,
           pad_out_o, pad_oe_o, uart_rx_o, spi_miso_o, exp_out, exp_oe, exp_rx, exp_miso);
  end

endmodule

bind padframe_top padframe_asserts #(
  .NUM_PADS ( NUM_PADS )
) i_asserts (.*);

/* hw/padframe_top.sv */
/*
 * Pad frame top level
 * Register-configured pad frame sharing a bank of pads between GPIO,
 * one UART and one SPI master
 */
module padframe_top #(
  parameter int unsigned NUM_PADS = 8
) (
  input  logic                    clk_i,
  input  logic                    reset_i,

  // Configuration bus
  input  logic                    reg_valid_i,
  input  logic                    reg_write_i,
  input  padframe_pkg::reg_addr_t reg_addr_i,
  input  padframe_pkg::reg_data_t reg_wdata_i,
  output logic                    reg_ready_o,
  output padframe_pkg::reg_data_t reg_rdata_o,
  output logic                    reg_error_o,

  // Peripherals
  input  logic                    uart_tx_i,
  output logic                    uart_rx_o,
  input  logic                    spi_sck_i,
  input  logic                    spi_mosi_i,
  input  logic                    spi_csn_i,
  output logic                    spi_miso_o,

  // Pads
  input  logic [NUM_PADS-1:0]     pad_in_i,
  output logic [NUM_PADS-1:0]     pad_out_o,
  output logic [NUM_PADS-1:0]     pad_oe_o
);
  import padframe_pkg::*;

  logic [NUM_PADS-1:0]     gpio_out;
  logic [NUM_PADS-1:0]     gpio_dir;
  pad_sel_e [NUM_PADS-1:0] pad_sel;

  padframe_cfg_regs #(
    .NUM_PADS ( NUM_PADS )
  ) i_cfg_regs (
    .clk_i       ( clk_i       ),
    .reset_i     ( reset_i     ),
    .reg_valid_i ( reg_valid_i ),
    .reg_write_i ( reg_write_i ),
    .reg_addr_i  ( reg_addr_i  ),
    .reg_wdata_i ( reg_wdata_i ),
    .reg_ready_o ( reg_ready_o ),
    .reg_rdata_o ( reg_rdata_o ),
    .reg_error_o ( reg_error_o ),
    .pad_in_i    ( pad_in_i    ),
    .gpio_out_o  ( gpio_out    ),
    .gpio_dir_o  ( gpio_dir    ),
    .pad_sel_o   ( pad_sel     )
  );

  pad_mux #(
    .NUM_PADS ( NUM_PADS )
  ) i_pad_mux (
    .pad_sel_i  ( pad_sel    ),
    .gpio_out_i ( gpio_out   ),
    .gpio_dir_i ( gpio_dir   ),
    .uart_tx_i  ( uart_tx_i  ),
    .spi_sck_i  ( spi_sck_i  ),
    .spi_mosi_i ( spi_mosi_i ),
    .spi_csn_i  ( spi_csn_i  ),
    .uart_rx_o  ( uart_rx_o  ),
    .spi_miso_o ( spi_miso_o ),
    .pad_in_i   ( pad_in_i   ),
    .pad_out_o  ( pad_out_o  ),
    .pad_oe_o   ( pad_oe_o   )
  );

endmodule

/* hw/pad_mux.sv */
/*
 * Pad multiplexer
 * Drives each pad's output and output enable from GPIO or a peripheral
 * according to the pad's function select, and routes pad inputs back
 * to the UART receiver and the SPI master. Purely combinational.
 */
module pad_mux #(
  parameter int unsigned NUM_PADS = 8
) (
  input  padframe_pkg::pad_sel_e [NUM_PADS-1:0] pad_sel_i,
  input  logic [NUM_PADS-1:0]                   gpio_out_i,
  input  logic [NUM_PADS-1:0]                   gpio_dir_i,

  input  logic                                  uart_tx_i,
  input  logic                                  spi_sck_i,
  input  logic                                  spi_mosi_i,
  input  logic                                  spi_csn_i,
  output logic                                  uart_rx_o,
  output logic                                  spi_miso_o,

  input  logic [NUM_PADS-1:0]                   pad_in_i,
  output logic [NUM_PADS-1:0]                   pad_out_o,
  output logic [NUM_PADS-1:0]                   pad_oe_o
);
  import padframe_pkg::*;

  // Output side, one slice per pad
  for (genvar i = 0; i < NUM_PADS; i++) begin : gen_pad
    logic pad_out;
    logic pad_oe;

    always_comb begin
      pad_out = 1'b0;
      pad_oe  = 1'b0;
      case (pad_sel_i[i])
        PAD_GPIO: begin
          pad_out = gpio_out_i[i];
          pad_oe  = gpio_dir_i[i];
        end
        PAD_UART_TX: begin
          pad_out = uart_tx_i;
          pad_oe  = 1'b1;
        end
        PAD_SPI_SCK: begin
          pad_out = spi_sck_i;
          pad_oe  = 1'b1;
        end
        PAD_SPI_MOSI: begin
          pad_out = spi_mosi_i;
          pad_oe  = 1'b1;
        end
        PAD_SPI_CSN: begin
          pad_out = spi_csn_i;
          pad_oe  = 1'b1;
        end
        // Input-only and unused pads stay released
        PAD_OFF,
        PAD_UART_RX,
        PAD_SPI_MISO: begin
          pad_out = 1'b0;
          pad_oe  = 1'b0;
        end
        default: begin
          pad_out = 1'b0;
          pad_oe  = 1'b0;
        end
      endcase
    end

    assign pad_out_o[i] = pad_out;
    assign pad_oe_o[i]  = pad_oe;
  end

  // Input side
  // Scan from the top so the lowest-numbered match wins
  always_comb begin
    uart_rx_o  = 1'b1;
    spi_miso_o = 1'b0;
    for (int i = NUM_PADS - 1; i >= 0; i--) begin
      if (pad_sel_i[i] == PAD_UART_RX) begin
        uart_rx_o = pad_in_i[i];
      end
      if (pad_sel_i[i] == PAD_SPI_MISO) begin
        spi_miso_o = pad_in_i[i];
      end
    end
  end

endmodule

/* hw/padframe_cfg_regs.sv */
/*
 * Pad frame configuration registers
 * Register bus slave with single-cycle response. Holds the GPIO output
 * and direction registers and one function select per pad, and reads
 * the pad inputs back through a two-flop synchronizer.
 */
module padframe_cfg_regs #(
  parameter int unsigned NUM_PADS = 8
) (
  input  logic                                  clk_i,
  input  logic                                  reset_i,

  input  logic                                  reg_valid_i,
  input  logic                                  reg_write_i,
  input  padframe_pkg::reg_addr_t               reg_addr_i,
  input  padframe_pkg::reg_data_t               reg_wdata_i,
  output logic                                  reg_ready_o,
  output padframe_pkg::reg_data_t               reg_rdata_o,
  output logic                                  reg_error_o,

  input  logic [NUM_PADS-1:0]                   pad_in_i,
  output logic [NUM_PADS-1:0]                   gpio_out_o,
  output logic [NUM_PADS-1:0]                   gpio_dir_o,
  output padframe_pkg::pad_sel_e [NUM_PADS-1:0] pad_sel_o
);
  import padframe_pkg::*;

  localparam int unsigned IDX_W = (NUM_PADS > 1) ? $clog2(NUM_PADS) : 1;

  if (NUM_PADS < 1 || NUM_PADS > MAX_PADS) begin : gen_num_pads_check
    $error("NUM_PADS must be between 1 and MAX_PADS");
  end

  logic [NUM_PADS-1:0]     gpio_out_q;
  logic [NUM_PADS-1:0]     gpio_dir_q;
  pad_sel_e [NUM_PADS-1:0] pad_sel_q;

  logic [NUM_PADS-1:0]     sync_q1;
  logic [NUM_PADS-1:0]     sync_q2;

  reg_addr_t               sel_offset;
  logic [IDX_W-1:0]        sel_idx;
  logic                    aligned;
  logic                    hit_gpio_out;
  logic                    hit_gpio_dir;
  logic                    hit_gpio_in;
  logic                    hit_sel;
  logic                    access_err;
  logic                    wr_en;

  // Address decode
  assign aligned      = (reg_addr_i[1:0] == 2'b00);
  assign hit_gpio_out = (reg_addr_i == REG_GPIO_OUT);
  assign hit_gpio_dir = (reg_addr_i == REG_GPIO_DIR);
  assign hit_gpio_in  = (reg_addr_i == REG_GPIO_IN);

  // Select window covers NUM_PADS words above the base
  assign sel_offset = reg_addr_i - REG_PAD_SEL_BASE;
  assign sel_idx    = sel_offset[IDX_W+1:2];
  assign hit_sel    = aligned
                   && (reg_addr_i >= REG_PAD_SEL_BASE)
                   && (sel_offset[REG_AW-1:2] < NUM_PADS);

  // Unmapped or unaligned addresses match nothing above
  assign access_err = !(hit_gpio_out || hit_gpio_dir || hit_gpio_in || hit_sel)
                   || (reg_write_i && hit_gpio_in);

  assign wr_en = reg_valid_i && reg_write_i && !access_err;

  // Slave never stalls
  assign reg_ready_o = reg_valid_i;
  assign reg_error_o = reg_valid_i && access_err;

  always_comb begin
    reg_rdata_o = '0;
    if (reg_valid_i && !reg_write_i && !access_err) begin
      if (hit_gpio_out) begin
        reg_rdata_o = reg_data_t'(gpio_out_q);
      end else if (hit_gpio_dir) begin
        reg_rdata_o = reg_data_t'(gpio_dir_q);
      end else if (hit_gpio_in) begin
        reg_rdata_o = reg_data_t'(sync_q2);
      end else begin
        reg_rdata_o = reg_data_t'(pad_sel_q[sel_idx]);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      gpio_out_q <= '0;
      gpio_dir_q <= '0;
      for (int i = 0; i < NUM_PADS; i++) begin
        pad_sel_q[i] <= PAD_OFF;
      end
    end else if (wr_en) begin
      if (hit_gpio_out) begin
        gpio_out_q <= reg_wdata_i[NUM_PADS-1:0];
      end
      if (hit_gpio_dir) begin
        gpio_dir_q <= reg_wdata_i[NUM_PADS-1:0];
      end
      // Every code is a valid function
      if (hit_sel) begin
        pad_sel_q[sel_idx] <= pad_sel_e'(reg_wdata_i[PAD_SEL_W-1:0]);
      end
    end
  end

  // Pad inputs are asynchronous to clk_i
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
    end else begin
      sync_q1 <= pad_in_i;
      sync_q2 <= sync_q1;
    end
  end

  assign gpio_out_o = gpio_out_q;
  assign gpio_dir_o = gpio_dir_q;
  assign pad_sel_o  = pad_sel_q;

endmodule

/* hw/padframe_pkg.sv */
/*
 * Pad frame package
 * Register bus types, register map and the per-pad function encoding
 * shared by the configuration registers and the pad multiplexer
 */
package padframe_pkg;

  // Register bus
  localparam int unsigned REG_AW = 32;
  localparam int unsigned REG_DW = 32;

  typedef logic [REG_AW-1:0] reg_addr_t;
  typedef logic [REG_DW-1:0] reg_data_t;

  // GPIO registers hold one bit per pad in a single word
  localparam int unsigned MAX_PADS = REG_DW;

  localparam int unsigned PAD_SEL_W = 3;

  // Function owning a pad
  typedef enum logic [PAD_SEL_W-1:0] {
    PAD_OFF      = 3'd0,
    PAD_GPIO     = 3'd1,
    PAD_UART_TX  = 3'd2,
    PAD_UART_RX  = 3'd3,
    PAD_SPI_SCK  = 3'd4,
    PAD_SPI_MOSI = 3'd5,
    PAD_SPI_MISO = 3'd6,
    PAD_SPI_CSN  = 3'd7
  } pad_sel_e;

  // Register map, byte offsets
  localparam reg_addr_t REG_GPIO_OUT     = 32'h0000_0000;
  localparam reg_addr_t REG_GPIO_DIR     = 32'h0000_0004;
  localparam reg_addr_t REG_GPIO_IN      = 32'h0000_0008;
  // One select word per pad from here on
  localparam reg_addr_t REG_PAD_SEL_BASE = 32'h0000_0010;

endpackage
